/* include/tile_macros.svh */
//##########################################################
// Compute tile sizes and constants
// Bus and flit widths, flit type codes, slave address map,
// boot ROM rule, NA register offsets, FIFO depth and credits
//##########################################################
`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

`define TILE_DATA_W      32           // Bus data width
`define TILE_ADDR_W      32           // Byte address width
`define TILE_SEL_W       4            // One select bit per byte
`define TILE_CNT_W       4            // FIFO and credit counters
`define TILE_FLIT_TYPE_W 2

`define FLIT_PAYLOAD     2'd0
`define FLIT_HEADER      2'd1
`define FLIT_LAST        2'd2
`define FLIT_SINGLE      2'd3

`define TILE_BASE_MASK   32'hF000_0000 // Slaves split on the top nibble
`define RAM_BASE         32'h0000_0000
`define ROM_BASE         32'hF000_0000
`define NA_BASE          32'hE000_0000

`define RAM_WORDS        1024
`define ROM_WORDS        16
`define ROM_PATTERN      32'h1500_0000 // Word index goes in the low bits

`define NA_OFS_TX        32'd0        // Word offsets inside NA window
`define NA_OFS_TX_LAST   32'd1
`define NA_OFS_RX        32'd2
`define NA_OFS_STATUS    32'd3
`define NA_OFS_CTRL      32'd4

`define MP_FIFO_DEPTH    8            // Transmit FIFO entries
`define MP_CREDITS       4            // Also the receive FIFO depth

`endif

/* hw/tile_pkg.sv */
//##########################################################
// Compute tile package
// Vector typedefs, bus request and response structs,
// NoC flit, message-passing push and status structs,
// transmit FSM state enum
//##########################################################
`default_nettype none

`include "tile_macros.svh"

package tile_pkg;

   typedef logic [`TILE_DATA_W-1:0]      word_t;
   typedef logic [`TILE_ADDR_W-1:0]      addr_t;
   typedef logic [`TILE_SEL_W-1:0]       sel_t;
   typedef logic [`TILE_FLIT_TYPE_W-1:0] flit_type_t;
   typedef logic [`TILE_CNT_W-1:0]       cnt_t;

   typedef struct packed {
      logic  stb;                        // Request strobe
      logic  we;                         // Write enable
      addr_t addr;
      word_t wdata;
      sel_t  sel;                        // Byte lanes of a write
   } bus_req_t;

   typedef struct packed {
      logic  ack;
      logic  err;
      word_t rdata;                      // Zero unless ack is high
   } bus_rsp_t;

   typedef struct packed {
      flit_type_t ftype;
      word_t      data;
   } noc_flit_t;

   typedef struct packed {
      logic  valid;                      // Push into transmit FIFO
      logic  last;                       // Flit closes the packet
      word_t data;
   } mp_push_t;

   typedef struct packed {
      word_t rx_data;                    // Head of receive FIFO
      cnt_t  rx_count;
      cnt_t  tx_count;
      cnt_t  credits;                    // Free output credits
   } mp_status_t;

   typedef enum logic {
      TX_IDLE,                           // Next flit opens a packet
      TX_BODY                            // Packet in progress
   } tx_state_e;

endpackage

`default_nettype wire

/* hw/tile_bus_decode.sv */
//##########################################################
// Single-master tile bus
// Address decode on the top nibble, strobe fan-out to
// RAM, boot ROM and NA, OR of the slave responses and
// error response for unmapped addresses
//##########################################################
`timescale 1ns/10ps
`default_nettype none

`include "tile_macros.svh"

module tile_bus_decode (
   input  wire               clk,
   input  wire               arst_n_i,
   input  tile_pkg::bus_req_t host_req_i,
   input  tile_pkg::bus_rsp_t ram_rsp_i,
   input  tile_pkg::bus_rsp_t rom_rsp_i,
   input  tile_pkg::bus_rsp_t na_rsp_i,
   output tile_pkg::bus_rsp_t host_rsp_o,
   output tile_pkg::bus_req_t ram_req_o,
   output tile_pkg::bus_req_t rom_req_o,
   output tile_pkg::bus_req_t na_req_o
);

   logic ram_hit;
   logic rom_hit;
   logic na_hit;
   logic unmapped_err_q;                 // Own error for holes in the map

   assign ram_hit = (host_req_i.addr & `TILE_BASE_MASK) == `RAM_BASE;
   assign rom_hit = (host_req_i.addr & `TILE_BASE_MASK) == `ROM_BASE;
   assign na_hit  = (host_req_i.addr & `TILE_BASE_MASK) == `NA_BASE;

   always_comb begin
      ram_req_o     = host_req_i;
      ram_req_o.stb = host_req_i.stb & ram_hit; // Only the matching slave sees stb
      rom_req_o     = host_req_i;
      rom_req_o.stb = host_req_i.stb & rom_hit;
      na_req_o      = host_req_i;
      na_req_o.stb  = host_req_i.stb & na_hit;
   end

   // One-cycle err, request held during it is not taken again
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         unmapped_err_q <= 1'b0;
      end else begin
         unmapped_err_q <= host_req_i.stb & ~(ram_hit | rom_hit | na_hit) & ~unmapped_err_q;
      end
   end

   // Idle slaves drive zeros, so OR is the mux
   assign host_rsp_o.ack   = ram_rsp_i.ack | rom_rsp_i.ack | na_rsp_i.ack;
   assign host_rsp_o.err   = ram_rsp_i.err | rom_rsp_i.err | na_rsp_i.err | unmapped_err_q;
   assign host_rsp_o.rdata = ram_rsp_i.rdata | rom_rsp_i.rdata | na_rsp_i.rdata;

endmodule

`default_nettype wire

/* hw/tile_ram.sv */
//##########################################################
// Local tile RAM
// Word-addressed memory, byte-select writes, registered
// read data and acknowledge
//##########################################################
`timescale 1ns/10ps
`default_nettype none

`include "tile_macros.svh"

module tile_ram (
   input  wire               clk,
   input  wire               arst_n_i,
   input  tile_pkg::bus_req_t req_i,
   output tile_pkg::bus_rsp_t rsp_o
);

   localparam int IDX_W = $clog2(`RAM_WORDS);

   tile_pkg::word_t mem [`RAM_WORDS];
   tile_pkg::word_t rdata_q;
   logic            ack_q;
   logic            take;
   logic [IDX_W-1:0] idx;

   assign take = req_i.stb & ~ack_q;     // Held request is not taken twice
   assign idx  = req_i.addr[IDX_W+1:2];  // Word index wraps at RAM_WORDS

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= take;                  // Reads and writes both ack
      end
   end

   always_ff @(posedge clk) begin
      if (take && req_i.we) begin
         for (int b = 0; b < `TILE_SEL_W; b++) begin
            if (req_i.sel[b]) begin
               mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8]; // Selected lanes only
            end
         end
      end
      if (take && !req_i.we) begin
         rdata_q <= mem[idx];
      end
   end

   assign rsp_o.ack   = ack_q;
   assign rsp_o.err   = 1'b0;            // Every RAM access is legal
   assign rsp_o.rdata = ack_q ? rdata_q : '0;

endmodule

`default_nettype wire

/* hw/tile_bootrom.sv */
//##########################################################
// Boot ROM
// Fixed-rule contents, read ack with data, err on writes
//##########################################################
`timescale 1ns/10ps
`default_nettype none

`include "tile_macros.svh"

module tile_bootrom (
   input  wire               clk,
   input  wire               arst_n_i,
   input  tile_pkg::bus_req_t req_i,
   output tile_pkg::bus_rsp_t rsp_o
);

   localparam int IDX_W = $clog2(`ROM_WORDS);

   logic            ack_q;
   logic            err_q;
   logic            take;
   tile_pkg::word_t rdata_q;

   assign take = req_i.stb & ~(ack_q | err_q);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= take & ~req_i.we;
         err_q <= take & req_i.we;       // ROM is read-only
      end
   end

   // Word i reads as the pattern with i in the low bits
   always_ff @(posedge clk) begin
      rdata_q <= `ROM_PATTERN | tile_pkg::word_t'(req_i.addr[IDX_W+1:2]);
   end

   assign rsp_o.ack   = ack_q;
   assign rsp_o.err   = err_q;
   assign rsp_o.rdata = ack_q ? rdata_q : '0;

endmodule

`default_nettype wire

/* hw/na_mp_regs.sv */
//##########################################################
// Message-passing NA register block
// Offset decode, CTRL register, full and empty checks,
// push and pop toward the link, STATUS packing, interrupt
//##########################################################
`timescale 1ns/10ps
`default_nettype none

`include "tile_macros.svh"

module na_mp_regs (
   input  wire                 clk,
   input  wire                 arst_n_i,
   input  tile_pkg::bus_req_t   req_i,
   input  tile_pkg::mp_status_t status_i,
   output tile_pkg::bus_rsp_t   rsp_o,
   output tile_pkg::mp_push_t   push_o,
   output logic                 rx_pop_o,
   output logic                 irq_o
);

   tile_pkg::addr_t ofs;                 // Word offset in NA window
   tile_pkg::word_t rd_data;
   tile_pkg::word_t rdata_q;
   logic            take;
   logic            bad;                 // Access answered with err
   logic            tx_full;
   logic            rx_empty;
   logic            ack_q;
   logic            err_q;
   logic            irq_en_q;            // CTRL bit 0

   assign ofs      = (req_i.addr & ~`TILE_BASE_MASK) >> 2;
   assign take     = req_i.stb & ~(ack_q | err_q);
   assign tx_full  = status_i.tx_count == tile_pkg::cnt_t'(`MP_FIFO_DEPTH);
   assign rx_empty = status_i.rx_count == '0;

   always_comb begin
      bad     = 1'b0;
      rd_data = '0;
      case (ofs)
         `NA_OFS_TX, `NA_OFS_TX_LAST: bad = req_i.we & tx_full; // Reads give zero
         `NA_OFS_RX: begin
            bad     = req_i.we | rx_empty;
            rd_data = status_i.rx_data;  // Head word comes with the pop
         end
         `NA_OFS_STATUS: begin
            bad     = req_i.we;
            rd_data = tile_pkg::word_t'({status_i.credits, status_i.tx_count,
                                         status_i.rx_count});
         end
         `NA_OFS_CTRL: rd_data = tile_pkg::word_t'(irq_en_q);
         default: bad = 1'b1;            // Unused offset
      endcase
   end

   assign push_o.valid = take & ~bad & req_i.we &
                         (ofs == `NA_OFS_TX || ofs == `NA_OFS_TX_LAST);
   assign push_o.last  = ofs == `NA_OFS_TX_LAST;
   assign push_o.data  = req_i.wdata;
   assign rx_pop_o     = take & ~bad & (ofs == `NA_OFS_RX);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q    <= 1'b0;
         err_q    <= 1'b0;
         irq_en_q <= 1'b0;
      end else begin
         ack_q <= take & ~bad;
         err_q <= take & bad;
         if (take && req_i.we && ofs == `NA_OFS_CTRL) begin
            irq_en_q <= req_i.wdata[0];  // Upper CTRL bits not implemented
         end
      end
   end

   always_ff @(posedge clk) begin
      rdata_q <= rd_data;
   end

   assign rsp_o.ack   = ack_q;
   assign rsp_o.err   = err_q;
   assign rsp_o.rdata = ack_q ? rdata_q : '0;

   assign irq_o = irq_en_q & ~rx_empty;  // Data waiting and enabled

endmodule

`default_nettype wire

/* hw/na_mp_link.sv */
//##########################################################
// Message-passing NA link
// Transmit FIFO with per-entry last flag, flit typing FSM,
// output credit counter, receive FIFO and input credits
//##########################################################
`timescale 1ns/10ps
`default_nettype none

`include "tile_macros.svh"

module na_mp_link (
   input  wire                  clk,
   input  wire                  arst_n_i,
   input  tile_pkg::mp_push_t   push_i,
   input  wire                  rx_pop_i,
   input  tile_pkg::noc_flit_t  noc_in_flit_i,
   input  wire                  noc_in_valid_i,
   input  wire                  noc_out_credit_i,
   output tile_pkg::mp_status_t status_o,
   output tile_pkg::noc_flit_t  noc_out_flit_o,
   output logic                 noc_out_valid_o,
   output logic                 noc_in_credit_o
);

   localparam int TX_PTR_W = $clog2(`MP_FIFO_DEPTH); // Power-of-two depths wrap
   localparam int RX_PTR_W = $clog2(`MP_CREDITS);

   tile_pkg::word_t     tx_data_mem [`MP_FIFO_DEPTH];
   logic                tx_last_mem [`MP_FIFO_DEPTH];
   logic [TX_PTR_W-1:0] tx_wr_ptr_q;
   logic [TX_PTR_W-1:0] tx_rd_ptr_q;
   tile_pkg::cnt_t      tx_count_q;
   tile_pkg::cnt_t      credits_q;
   tile_pkg::tx_state_e tx_state_q;
   tile_pkg::noc_flit_t out_flit_q;
   logic                out_valid_q;
   logic                send;
   logic                head_last;

   tile_pkg::word_t     rx_mem [`MP_CREDITS];
   logic [RX_PTR_W-1:0] rx_wr_ptr_q;
   logic [RX_PTR_W-1:0] rx_rd_ptr_q;
   tile_pkg::cnt_t      rx_count_q;
   logic                pop_q;
   logic                in_credit_q;

   assign send      = (tx_count_q != '0) && (credits_q != '0);
   assign head_last = tx_last_mem[tx_rd_ptr_q];

   // Transmit side
   always_ff @(posedge clk) begin
      if (push_i.valid) begin
         tx_data_mem[tx_wr_ptr_q] <= push_i.data;
         tx_last_mem[tx_wr_ptr_q] <= push_i.last;
      end
      if (send) begin
         out_flit_q.data <= tx_data_mem[tx_rd_ptr_q];
         if (tx_state_q == tile_pkg::TX_IDLE) begin
            out_flit_q.ftype <= head_last ? `FLIT_SINGLE : `FLIT_HEADER;
         end else begin
            out_flit_q.ftype <= head_last ? `FLIT_LAST : `FLIT_PAYLOAD;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tx_wr_ptr_q <= '0;
         tx_rd_ptr_q <= '0;
         tx_count_q  <= '0;
         credits_q   <= tile_pkg::cnt_t'(`MP_CREDITS);
         tx_state_q  <= tile_pkg::TX_IDLE;
         out_valid_q <= 1'b0;
      end else begin
         tx_wr_ptr_q <= tx_wr_ptr_q + TX_PTR_W'(push_i.valid); // Full checked in regs
         tx_rd_ptr_q <= tx_rd_ptr_q + TX_PTR_W'(send);
         tx_count_q  <= tx_count_q + tile_pkg::cnt_t'(push_i.valid)
                        - tile_pkg::cnt_t'(send);
         credits_q   <= credits_q - tile_pkg::cnt_t'(send)
                        + tile_pkg::cnt_t'(noc_out_credit_i);
         out_valid_q <= send;             // One flit per cycle at most
         if (send) begin
            tx_state_q <= head_last ? tile_pkg::TX_IDLE : tile_pkg::TX_BODY;
         end
      end
   end

   // Receive side
   always_ff @(posedge clk) begin
      if (noc_in_valid_i) begin
         rx_mem[rx_wr_ptr_q] <= noc_in_flit_i.data; // Incoming type dropped
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rx_wr_ptr_q <= '0;
         rx_rd_ptr_q <= '0;
         rx_count_q  <= '0;
         pop_q       <= 1'b0;
         in_credit_q <= 1'b0;
      end else begin
         rx_wr_ptr_q <= rx_wr_ptr_q + RX_PTR_W'(noc_in_valid_i); // Sender holds credit
         rx_rd_ptr_q <= rx_rd_ptr_q + RX_PTR_W'(rx_pop_i);
         rx_count_q  <= rx_count_q + tile_pkg::cnt_t'(noc_in_valid_i)
                        - tile_pkg::cnt_t'(rx_pop_i);
         pop_q       <= rx_pop_i;         // Aligned with the pop ack
         in_credit_q <= pop_q;            // Credit in the cycle after ack
      end
   end

   assign noc_out_flit_o  = out_flit_q;
   assign noc_out_valid_o = out_valid_q;
   assign noc_in_credit_o = in_credit_q;

   assign status_o.rx_data  = rx_mem[rx_rd_ptr_q];
   assign status_o.rx_count = rx_count_q;
   assign status_o.tx_count = tx_count_q;
   assign status_o.credits  = credits_q;

endmodule

`default_nettype wire

/* hw/compute_tile.sv */
//##########################################################
// Compute tile top level
// Host bus port, bus decoder, RAM, boot ROM and
// message-passing network adapter
//##########################################################
`timescale 1ns/10ps
`default_nettype none

module compute_tile (
   input  wire                 clk,
   input  wire                 arst_n_i,
   input  tile_pkg::bus_req_t  host_req_i,
   output tile_pkg::bus_rsp_t  host_rsp_o,
   input  tile_pkg::noc_flit_t noc_in_flit_i,
   input  wire                 noc_in_valid_i,
   output logic                noc_in_credit_o,
   output tile_pkg::noc_flit_t noc_out_flit_o,
   output logic                noc_out_valid_o,
   input  wire                 noc_out_credit_i,
   output logic                irq_o
);

   tile_pkg::bus_req_t   ram_req;
   tile_pkg::bus_req_t   rom_req;
   tile_pkg::bus_req_t   na_req;
   tile_pkg::bus_rsp_t   ram_rsp;
   tile_pkg::bus_rsp_t   rom_rsp;
   tile_pkg::bus_rsp_t   na_rsp;
   tile_pkg::mp_push_t   mp_push;         // Regs to link
   logic                 mp_rx_pop;
   tile_pkg::mp_status_t mp_status;       // Link to regs

   tile_bus_decode tile_bus_decode_i (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .host_req_i (host_req_i),
      .ram_rsp_i  (ram_rsp),
      .rom_rsp_i  (rom_rsp),
      .na_rsp_i   (na_rsp),
      .host_rsp_o (host_rsp_o),
      .ram_req_o  (ram_req),
      .rom_req_o  (rom_req),
      .na_req_o   (na_req)
   );

   tile_ram tile_ram_i (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .req_i    (ram_req),
      .rsp_o    (ram_rsp)
   );

   tile_bootrom tile_bootrom_i (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .req_i    (rom_req),
      .rsp_o    (rom_rsp)
   );

   na_mp_regs na_mp_regs_i (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .req_i    (na_req),
      .status_i (mp_status),
      .rsp_o    (na_rsp),
      .push_o   (mp_push),
      .rx_pop_o (mp_rx_pop),
      .irq_o    (irq_o)
   );

   na_mp_link na_mp_link_i (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .push_i           (mp_push),
      .rx_pop_i         (mp_rx_pop),
      .noc_in_flit_i    (noc_in_flit_i),
      .noc_in_valid_i   (noc_in_valid_i),
      .noc_out_credit_i (noc_out_credit_i),
      .status_o         (mp_status),
      .noc_out_flit_o   (noc_out_flit_o),
      .noc_out_valid_o  (noc_out_valid_o),
      .noc_in_credit_o  (noc_in_credit_o)
   );

endmodule

`default_nettype wire

/* test/compute_tile_asserts.sv */
//##########################################################
// Compute tile protocol properties
// Bus response exclusivity and length, output credit
// guard and receive FIFO bound, bound into the decoder
// and the NA link
//##########################################################
`timescale 1ns/10ps
`default_nettype none

`include "tile_macros.svh"

module compute_tile_asserts (
   input wire                clk,
   input wire                arst_n_i,
   input tile_pkg::bus_rsp_t rsp_i,
   input wire                out_valid_i,
   input tile_pkg::cnt_t     credits_i,
   input tile_pkg::cnt_t     rx_count_i
);

   int unsigned fail_cnt = 0;             // Failed properties so far

   ack_err_apart: assert property (@(posedge clk) disable iff (!arst_n_i)
      !(rsp_i.ack && rsp_i.err)) else begin
      fail_cnt++;
      $error("ack and err high in the same cycle");
   end

   rsp_one_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
      (rsp_i.ack || rsp_i.err) |=> !(rsp_i.ack || rsp_i.err)) else begin
      fail_cnt++;
      $error("bus response held longer than one cycle");
   end

   // Flit leaves one cycle after the send decision
   send_with_credit: assert property (@(posedge clk) disable iff (!arst_n_i)
      out_valid_i |-> $past(credits_i) != '0) else begin
      fail_cnt++;
      $error("flit sent without an output credit");
   end

   rx_bounded: assert property (@(posedge clk) disable iff (!arst_n_i)
      rx_count_i <= tile_pkg::cnt_t'(`MP_CREDITS)) else begin
      fail_cnt++;
      $error("receive FIFO holds more flits than credits");
   end

endmodule

bind tile_bus_decode compute_tile_asserts bus_asserts_i (
   .clk (clk), .arst_n_i (arst_n_i), .rsp_i (host_rsp_o),
   .out_valid_i (1'b0), .credits_i ('0), .rx_count_i ('0)
);

bind na_mp_link compute_tile_asserts link_asserts_i (
   .clk (clk), .arst_n_i (arst_n_i), .rsp_i ('0),
   .out_valid_i (noc_out_valid_o), .credits_i (credits_q), .rx_count_i (rx_count_q)
);

`default_nettype wire

/* test/tb_compute_tile.sv */
//##########################################################
// Compute tile testbench
// Clock and reset, random host and NoC stimulus from a
// fixed seed, reference model of RAM, ROM and the NA
// queues, output credit return, checks and timeout
//##########################################################
`timescale 1ns/10ps
`default_nettype none

`include "tile_macros.svh"

module tb_compute_tile;

   localparam int TIMEOUT_CYCLES = 6000;   // About four times the sequence

   logic                clk;
   logic                arst_n;
   tile_pkg::bus_req_t  host_req;
   tile_pkg::bus_rsp_t  host_rsp;
   tile_pkg::noc_flit_t noc_in_flit;
   logic                noc_in_valid;
   logic                noc_in_credit;
   tile_pkg::noc_flit_t noc_out_flit;
   logic                noc_out_valid;
   logic                noc_out_credit = 1'b0;
   logic                irq;

   integer seed        = 32'h3d5a_f61f;
   integer credit_seed = 32'h3d5a_f61f ^ 32'h0f0f_0f0f; // Receiver side stream

   tile_pkg::word_t ram_model [`RAM_WORDS];
   tile_pkg::sel_t  ram_known [`RAM_WORDS];   // Bytes written so far
   logic [32:0]     tx_q [$];                 // Last flag over pushed word
   tile_pkg::word_t rx_q [$];
   int              out_in_flight    = 0;     // Flits not yet credited back
   int              injected         = 0;
   int              pops             = 0;
   int              in_credit_pulses = 0;
   int              fail_count       = 0;
   int              cycle            = 0;
   logic            tx_open      = 1'b0;      // Packet open on the NoC
   logic            hold_credits = 1'b0;
   logic            irq_en_model = 1'b0;

   compute_tile compute_tile_i (
      .clk              (clk),
      .arst_n_i         (arst_n),
      .host_req_i       (host_req),
      .host_rsp_o       (host_rsp),
      .noc_in_flit_i    (noc_in_flit),
      .noc_in_valid_i   (noc_in_valid),
      .noc_in_credit_o  (noc_in_credit),
      .noc_out_flit_o   (noc_out_flit),
      .noc_out_valid_o  (noc_out_valid),
      .noc_out_credit_i (noc_out_credit),
      .irq_o            (irq)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;             // 100 ns period
   end

   always @(posedge clk) begin
      cycle++;
      if (cycle >= TIMEOUT_CYCLES) begin
         $display("Timeout: test sequence not finished after %0d cycles", TIMEOUT_CYCLES);
         $display(">>> FAIL");
         $fatal(1, "run stopped by timeout");
      end
   end

   task automatic fail_now(input string what);
      fail_count++;
      $display("%s", what);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
      assert (act === exp) else begin
         fail_count++;
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         $display(">>> FAIL");
         $fatal(1, "stopped at first error");
      end
   endtask

   // One access, response expected at the first edge after take
   task automatic bus_access(input string name, input logic we, input tile_pkg::addr_t addr,
                             input tile_pkg::word_t wdata, input tile_pkg::sel_t sel,
                             input logic exp_err, output tile_pkg::word_t rdata);
      host_req.stb   = 1'b1;
      host_req.we    = we;
      host_req.addr  = addr;
      host_req.wdata = wdata;
      host_req.sel   = sel;
      @(posedge clk);                     // Request taken
      @(negedge clk);
      check_eq({name, " ack"}, !exp_err, host_rsp.ack);
      check_eq({name, " err"}, exp_err, host_rsp.err);
      rdata = host_rsp.rdata;
      @(negedge clk);                     // Request held over the response edge
      check_eq({name, " single response"}, 2'b00, {host_rsp.ack, host_rsp.err});
      host_req = '0;
   endtask

   // Receiver of the outgoing flits and sender-side credit count
   always @(negedge clk) begin : noc_side
      logic [32:0]          head;
      tile_pkg::flit_type_t exp_type;
      if (noc_out_valid) begin
         assert (tx_q.size() != 0) else fail_now("Flit left the tile with no word pushed");
         head = tx_q.pop_front();
         if (tx_open) begin
            exp_type = head[32] ? `FLIT_LAST : `FLIT_PAYLOAD;
         end else begin
            exp_type = head[32] ? `FLIT_SINGLE : `FLIT_HEADER; // First flit of a packet
         end
         check_eq("tx flit data", head[31:0], noc_out_flit.data);
         check_eq("tx flit type", exp_type, noc_out_flit.ftype);
         tx_open = ~head[32];
         out_in_flight++;
         assert (out_in_flight <= `MP_CREDITS)
            else fail_now("More flits in flight than credits returned");
      end
      noc_out_credit = 1'b0;
      if (!hold_credits && out_in_flight > 0 && ($random(credit_seed) & 3) == 0) begin
         noc_out_credit = 1'b1;           // Flit consumed after a random delay
         out_in_flight--;
      end
      if (noc_in_credit) begin
         in_credit_pulses++;
      end
      assert (compute_tile_i.tile_bus_decode_i.bus_asserts_i.fail_cnt == 0 &&
              compute_tile_i.na_mp_link_i.link_asserts_i.fail_cnt == 0)
         else fail_now("A bound protocol assertion failed");
   end

   task automatic wait_tx_quiet();
      while (tx_q.size() != 0 || out_in_flight != 0) begin
         @(negedge clk);
      end
      @(negedge clk);                     // Last credit pulse lands
   endtask

   task automatic check_status();
      tile_pkg::word_t rdata;
      wait_tx_quiet();
      bus_access("status read", 1'b0, `NA_BASE | (`NA_OFS_STATUS << 2), '0, '0, 1'b0, rdata);
      check_eq("status", (`MP_CREDITS << 8) | rx_q.size(), rdata);
      check_eq("rx credit pulses", pops, in_credit_pulses);
   endtask

   task automatic test_ram();
      tile_pkg::word_t rdata;
      tile_pkg::word_t wdata;
      tile_pkg::word_t mask;
      tile_pkg::addr_t addr;
      tile_pkg::sel_t  sel;
      logic            we;
      int              idx;
      for (int n = 0; n < 200; n++) begin
         addr  = ($random(seed) & 32'h0FFF_F000) | (({$random(seed)} % 32) << 2);
         idx   = (addr >> 2) % `RAM_WORDS;  // Upper bits alias
         we    = ($random(seed) & 1) != 0;
         sel   = tile_pkg::sel_t'($random(seed));
         wdata = $random(seed);
         bus_access("ram", we, addr, wdata, sel, 1'b0, rdata);
         mask = '0;
         for (int b = 0; b < `TILE_SEL_W; b++) begin
            if (we && sel[b]) begin
               ram_model[idx][8*b +: 8] = wdata[8*b +: 8];
               ram_known[idx][b]        = 1'b1;
            end
            if (ram_known[idx][b]) begin
               mask[8*b +: 8] = 8'hFF;
            end
         end
         if (!we) begin
            check_eq("ram read", ram_model[idx] & mask, rdata & mask);
         end
      end
   endtask

   task automatic test_rom_unmapped();
      tile_pkg::word_t rdata;
      tile_pkg::addr_t addr;
      int              ofs;
      for (int i = 0; i < `ROM_WORDS; i++) begin
         addr = `ROM_BASE | ($random(seed) & 32'h0FFF_FFC0) | (i << 2);
         bus_access("rom read", 1'b0, addr, '0, '0, 1'b0, rdata);
         check_eq("rom read", `ROM_PATTERN | ((addr >> 2) % `ROM_WORDS), rdata);
      end
      for (int n = 0; n < 10; n++) begin
         addr = `ROM_BASE | ($random(seed) & 32'h0FFF_FFFC);
         bus_access("rom write", 1'b1, addr, $random(seed), 4'hF, 1'b1, rdata);
         addr = ((1 + {$random(seed)} % 13) << 28) | ($random(seed) & 32'h0FFF_FFFC);
         bus_access("unmapped", $random(seed) & 1, addr, $random(seed), 4'hF, 1'b1, rdata);
         ofs = 5 + {$random(seed)} % 59;
         addr = `NA_BASE | (ofs << 2);
         bus_access("na unused offset", $random(seed) & 1, addr, '0, 4'hF, 1'b1, rdata);
      end
      bus_access("rx write", 1'b1, `NA_BASE | (`NA_OFS_RX << 2), '0, 4'hF, 1'b1, rdata);
      bus_access("status write", 1'b1, `NA_BASE | (`NA_OFS_STATUS << 2), '0, 4'hF, 1'b1, rdata);
   endtask

   task automatic push_word(input logic last);
      tile_pkg::word_t rdata;
      tile_pkg::word_t wdata;
      tile_pkg::addr_t addr;
      wdata = $random(seed);
      addr  = `NA_BASE | ((last ? `NA_OFS_TX_LAST : `NA_OFS_TX) << 2);
      while (tx_q.size() >= `MP_FIFO_DEPTH) begin
         @(negedge clk);                  // Room left in the transmit FIFO
      end
      tx_q.push_back({last, wdata});
      bus_access("tx push", 1'b1, addr, wdata, 4'hF, 1'b0, rdata);
   endtask

   task automatic test_transmit();
      tile_pkg::word_t rdata;
      int              len;
      for (int p = 0; p < 30; p++) begin
         len = 1 + {$random(seed)} % 5;
         for (int w = 0; w < len; w++) begin
            push_word(w == len - 1);
         end
      end
      check_status();
      hold_credits = 1'b1;                // Credits run out, FIFO fills
      for (int w = 0; w < `MP_FIFO_DEPTH + `MP_CREDITS; w++) begin
         push_word(1'b0);
      end
      bus_access("tx push full", 1'b1, `NA_BASE | (`NA_OFS_TX_LAST << 2), $random(seed),
                 4'hF, 1'b1, rdata);
      hold_credits = 1'b0;
      wait_tx_quiet();
      push_word(1'b1);                    // Closes the open packet
      check_status();
   endtask

   task automatic inject_flit();
      noc_in_flit.ftype = tile_pkg::flit_type_t'($random(seed)); // Tile drops the type
      noc_in_flit.data  = $random(seed);
      noc_in_valid      = 1'b1;
      rx_q.push_back(noc_in_flit.data);
      injected++;
      @(negedge clk);
      noc_in_valid = 1'b0;
   endtask

   task automatic pop_rx();
      tile_pkg::word_t rdata;
      logic            empty;
      empty = rx_q.size() == 0;
      bus_access("rx pop", 1'b0, `NA_BASE | (`NA_OFS_RX << 2), '0, '0, empty, rdata);
      if (!empty) begin
         check_eq("rx data", rx_q.pop_front(), rdata);
         pops++;
         check_eq("rx credit after pop", 1'b1, noc_in_credit);
      end
   endtask

   task automatic test_receive();
      tile_pkg::word_t rdata;
      tile_pkg::word_t wdata;
      int              choice;
      for (int n = 0; n < 80; n++) begin
         choice = {$random(seed)} % 4;
         if (choice < 2 && injected - in_credit_pulses < `MP_CREDITS) begin
            inject_flit();
         end else if (choice == 2) begin
            pop_rx();
         end else begin
            wdata = $random(seed);
            bus_access("ctrl write", 1'b1, `NA_BASE | (`NA_OFS_CTRL << 2), wdata, 4'hF,
                       1'b0, rdata);
            irq_en_model = wdata[0];
            bus_access("ctrl read", 1'b0, `NA_BASE | (`NA_OFS_CTRL << 2), '0, '0, 1'b0, rdata);
            check_eq("ctrl read", irq_en_model, rdata);
         end
         check_eq("irq", irq_en_model & (rx_q.size() != 0), irq);
         if (n % 20 == 19) begin
            check_status();
         end
      end
      while (rx_q.size() != 0) begin
         pop_rx();
      end
      pop_rx();                           // Empty FIFO answers err
      check_eq("irq idle", 1'b0, irq);
   endtask

   initial begin
      host_req     = '0;
      noc_in_flit  = '0;
      noc_in_valid = 1'b0;
      arst_n       = 1'b0;
      for (int i = 0; i < `RAM_WORDS; i++) begin
         ram_known[i] = '0;
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      check_eq("reset outputs", 5'b0,
               {host_rsp.ack, host_rsp.err, noc_out_valid, noc_in_credit, irq});
      test_ram();
      test_rom_unmapped();
      test_transmit();
      test_receive();
      check_status();
      if (fail_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
hw/tile_pkg.sv
hw/tile_bus_decode.sv
hw/tile_ram.sv
hw/tile_bootrom.sv
hw/na_mp_regs.sv
hw/na_mp_link.sv
hw/compute_tile.sv
test/compute_tile_asserts.sv
test/tb_compute_tile.sv

/* run.sh */
#!/bin/sh
# Build the compute tile testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
   --top-module tb_compute_tile -Mdir obj_dir -o sim_tb ||
   { echo "build failed"; exit 1; }

./obj_dir/sim_tb | tee /dev/stderr | grep -qx '>>> PASS' &&
   echo "simulation passed" ||
   { echo "simulation failed"; exit 1; }
